// ==== rtl/bmu_alu.sv ====
////////////////////////////////////////
// Combinational ALU for the Zba/Zbb/Zbc/Zbs operators
// Shift amounts and bit indices use operand B [4:0]
// NOP yields zero
////////////////////////////////////////
`timescale 1ns/1ns

module bmu_alu (
  bmu_ex_if.ex        ex,
  output logic [31:0] result_o
);

  import bmu_isa_pkg::*;

  logic [31:0] a;
  logic [31:0] b;
  logic [4:0]  shamt;
  logic [63:0] rot_l;       // Upper half is rol
  logic [63:0] rot_r;       // Lower half is ror
  logic [63:0] clmul_prod;  // Full carry-less product, shared by all three forms
  logic [31:0] a_rev;
  logic [31:0] orc;
  logic [31:0] bit_mask;
  logic [5:0]  clz_cnt;
  logic [5:0]  ctz_cnt;
  logic [5:0]  cpop_cnt;

  // Index of lowest set bit, 32 when none
  function automatic logic [5:0] trailing_zeros(input logic [31:0] v);
    logic [5:0] n;
    n = 6'd32;
    for (int i = 31; i >= 0; i--) begin
      if (v[i]) n = 6'(i);
    end
    return n;
  endfunction

  assign a        = ex.operand_a;
  assign b        = ex.operand_b;
  assign shamt    = b[4:0];
  assign rot_l    = {a, a} << shamt;
  assign rot_r    = {a, a} >> shamt;
  assign bit_mask = 32'd1 << shamt;
  assign ctz_cnt  = trailing_zeros(a);
  assign clz_cnt  = trailing_zeros(a_rev); // clz as ctz of reversed word

  ////////////////////////////////////////
  // Bit reverse, popcount, clmul, orc.b
  ////////////////////////////////////////
  always_comb begin
    cpop_cnt   = '0;
    clmul_prod = '0;
    for (int i = 0; i < 32; i++) begin
      a_rev[i] = a[31-i];
      cpop_cnt = cpop_cnt + 6'(a[i]);
      if (b[i]) clmul_prod = clmul_prod ^ ({32'd0, a} << i); // XOR, no carries
    end
    for (int j = 0; j < 4; j++) begin
      orc[8*j +: 8] = {8{|a[8*j +: 8]}}; // Any bit set fills the byte
    end
  end

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////
  always_comb begin
    unique case (ex.alu_operator)
      ALU_B_SH1ADD: result_o = (a << 1) + b;
      ALU_B_SH2ADD: result_o = (a << 2) + b;
      ALU_B_SH3ADD: result_o = (a << 3) + b;
      ALU_B_MIN:    result_o = ($signed(a) < $signed(b)) ? a : b;
      ALU_B_MINU:   result_o = (a < b) ? a : b;
      ALU_B_MAX:    result_o = ($signed(a) < $signed(b)) ? b : a;
      ALU_B_MAXU:   result_o = (a < b) ? b : a;
      ALU_B_ANDN:   result_o = a & ~b;
      ALU_B_ORN:    result_o = a | ~b;
      ALU_B_XNOR:   result_o = ~(a ^ b);
      ALU_B_ROL:    result_o = rot_l[63:32];
      ALU_B_ROR:    result_o = rot_r[31:0];
      ALU_B_CLZ:    result_o = {26'd0, clz_cnt};
      ALU_B_CTZ:    result_o = {26'd0, ctz_cnt};
      ALU_B_CPOP:   result_o = {26'd0, cpop_cnt};
      ALU_B_ORC_B:  result_o = orc;
      ALU_B_REV8:   result_o = {a[7:0], a[15:8], a[23:16], a[31:24]}; // Byte swap
      ALU_B_SEXT_B: result_o = {{24{a[7]}}, a[7:0]};
      ALU_B_SEXT_H: result_o = {{16{a[15]}}, a[15:0]};
      ALU_B_ZEXT_H: result_o = {16'd0, a[15:0]};
      ALU_B_CLMUL:  result_o = clmul_prod[31:0];
      ALU_B_CLMULH: result_o = clmul_prod[63:32];
      ALU_B_CLMULR: result_o = clmul_prod[62:31]; // Same as rev(clmul(rev a, rev b))
      ALU_B_BSET:   result_o = a | bit_mask;
      ALU_B_BCLR:   result_o = a & ~bit_mask;
      ALU_B_BINV:   result_o = a ^ bit_mask;
      ALU_B_BEXT:   result_o = {31'd0, a[shamt]};
      default:      result_o = '0; // NOP
    endcase
  end

  // Decoder and pipeline must hand over a real operator for legal work
  always_comb begin
    legal_op_a : assert final (!(ex.valid && !ex.illegal) || (ex.alu_operator != ALU_B_NOP))
      else $error("legal instruction in execute with NOP operator");
  end

endmodule

// ==== rtl/bmu_core.sv ====
////////////////////////////////////////
// Decode/execute slice for RV32 B instructions
// One instruction per cycle, no back-pressure, retire 1 cycle after issue
// Preload only while both stages are empty
////////////////////////////////////////
`timescale 1ns/1ns

module bmu_core #(
  parameter bmu_isa_pkg::b_ext_e B_EXT  = bmu_isa_pkg::ZBA_ZBB_ZBC_ZBS,
  parameter bit                  ZC_EXT = 1'b1
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        instr_valid_i,
  input  logic [31:0] instr_i,
  input  logic        instr_compressed_i,
  input  logic        pl_we_i,
  input  logic [4:0]  pl_addr_i,
  input  logic [31:0] pl_data_i,
  output logic        retire_valid_o,
  output logic        retire_illegal_o,
  output logic [4:0]  retire_rd_o,
  output logic [31:0] retire_result_o
);

  import bmu_isa_pkg::*;
  import bmu_ctrl_pkg::*;

  instr_u        instr;
  decoder_ctrl_t ctrl;
  logic [31:0]   rf_rdata_a, rf_rdata_b;
  logic          fwd_ok, fwd_a, fwd_b;  // Execute result usable for decode
  logic [31:0]   rs1_val, rs2_val;
  logic [31:0]   op_a, op_b;
  logic [31:0]   alu_result;
  logic          wb_we;
  logic          rf_we;
  logic [4:0]    rf_waddr;
  logic [31:0]   rf_wdata;

  bmu_ex_if ex_if ();

  assign instr = instr_i;

  bmu_decoder #(.B_EXT(B_EXT), .ZC_EXT(ZC_EXT)) u_decoder (
    .instr_i            (instr),
    .instr_compressed_i (instr_compressed_i),
    .decoder_ctrl_o     (ctrl)
  );

  bmu_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (instr.r.rs1),
    .raddr_b_i (instr.r.rs2),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

  bmu_alu u_alu (
    .ex       (ex_if.ex),
    .result_o (alu_result)
  );

  ////////////////////////////////////////
  // Operands with forwarding from execute
  ////////////////////////////////////////
  assign fwd_ok  = ex_if.valid && !ex_if.illegal && ex_if.rf_we && (ex_if.rd != 5'd0);
  assign fwd_a   = fwd_ok && ctrl.rf_re[0] && (ex_if.rd == instr.r.rs1);
  assign fwd_b   = fwd_ok && ctrl.rf_re[1] && (ex_if.rd == instr.r.rs2);
  assign rs1_val = fwd_a ? alu_result : rf_rdata_a;
  assign rs2_val = fwd_b ? alu_result : rf_rdata_b;
  assign op_a    = (ctrl.alu_op_a_mux_sel == OP_A_REGA_OR_FWD) ? rs1_val : '0;

  always_comb begin
    case (ctrl.alu_op_b_mux_sel)
      OP_B_REGB_OR_FWD: op_b = rs2_val;
      OP_B_IMM:         op_b = {27'd0, instr.i.imm12[4:0]}; // Shamt or bit index
      default:          op_b = '0;
    endcase
  end

  ////////////////////////////////////////
  // Pipeline register and retire
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_if.valid      <= 1'b0;
      ex_if.rf_we      <= 1'b0;
      ex_if.illegal    <= 1'b0;
      retire_valid_o   <= 1'b0;
      retire_illegal_o <= 1'b0;
    end else begin
      ex_if.valid      <= instr_valid_i;
      if (instr_valid_i) begin
        ex_if.rf_we   <= ctrl.rf_we && ctrl.alu_en;
        ex_if.illegal <= ctrl.illegal_insn;
      end
      retire_valid_o   <= ex_if.valid;                  // Single-cycle pulse per instr
      retire_illegal_o <= ex_if.valid && ex_if.illegal;
    end
  end

  // Payload, qualified by the valid bits above
  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      ex_if.alu_operator <= ctrl.alu_operator;
      ex_if.operand_a    <= op_a;
      ex_if.operand_b    <= op_b;
      ex_if.rd           <= instr.r.rd;
    end
    if (ex_if.valid) begin
      retire_rd_o     <= ex_if.rd;
      retire_result_o <= ex_if.illegal ? '0 : alu_result; // Illegal reports zero
    end
  end

  // Write-back, preload wins on a collision
  assign wb_we    = ex_if.valid && !ex_if.illegal && ex_if.rf_we;
  assign rf_we    = pl_we_i || wb_we;
  assign rf_waddr = pl_we_i ? pl_addr_i : ex_if.rd;
  assign rf_wdata = pl_we_i ? pl_data_i : alu_result;

  // Preload may not overlap an instruction in decode or execute
  pl_quiet_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pl_we_i |-> (!instr_valid_i && !ex_if.valid))
    else $error("preload write while an instruction is in flight");

endmodule

// ==== rtl/bmu_ctrl_pkg.sv ====
////////////////////////////////////////
// Decoder control word for the B slice
// The illegal value keeps every enable low
////////////////////////////////////////
package bmu_ctrl_pkg;

  import bmu_isa_pkg::*;

  // Control produced by the decoder, 13 bits
  typedef struct packed {
    logic       illegal_insn;
    logic       alu_en;
    alu_op_e    alu_operator;
    op_a_sel_e  alu_op_a_mux_sel;
    op_b_sel_e  alu_op_b_mux_sel;
    logic [1:0] rf_re;  // [0] rs1, [1] rs2
    logic       rf_we;
  } decoder_ctrl_t;

  // Default for anything not claimed by an enabled extension
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL_INSN = '{
    illegal_insn     : 1'b1,
    alu_en           : 1'b0,
    alu_operator     : ALU_B_NOP,
    alu_op_a_mux_sel : OP_A_NONE,
    alu_op_b_mux_sel : OP_B_NONE,
    rf_re            : 2'b00,
    rf_we            : 1'b0
  };

endpackage

// ==== rtl/bmu_decoder.sv ====
////////////////////////////////////////
// Combinational B-extension decoder, OP and OP-IMM only
// A disabled extension decodes as illegal
// sext.b, sext.h, zext.h also legal as Zcb when compressed
////////////////////////////////////////
`timescale 1ns/1ns

module bmu_decoder #(
  parameter bmu_isa_pkg::b_ext_e B_EXT  = bmu_isa_pkg::B_NONE,
  parameter bit                  ZC_EXT = 1'b0
) (
  input  bmu_isa_pkg::instr_u         instr_i,
  input  logic                        instr_compressed_i,
  output bmu_ctrl_pkg::decoder_ctrl_t decoder_ctrl_o
);

  import bmu_isa_pkg::*;
  import bmu_ctrl_pkg::*;

  // Extension flags from the configuration
  localparam bit RV32B_ZBA = (B_EXT != B_NONE);
  localparam bit RV32B_ZBB = (B_EXT != B_NONE);
  localparam bit RV32B_ZBS = (B_EXT != B_NONE);
  localparam bit RV32B_ZBC = (B_EXT == ZBA_ZBB_ZBC_ZBS);

  logic      zcb_ok; // Extension ops allowed through Zbb or Zcb
  alu_op_e   op;
  op_b_sel_e b_sel;

  assign zcb_ok = RV32B_ZBB || (ZC_EXT && instr_compressed_i);

  always_comb begin
    op    = ALU_B_NOP;
    b_sel = OP_B_NONE;

    unique case (instr_i.r.opcode)
      OPCODE_OP: begin
        b_sel = OP_B_REGB_OR_FWD;
        // R view, funct7 and funct3 select the op
        unique case ({instr_i.r.funct7, instr_i.r.funct3})
          {7'b001_0000, 3'b010}: if (RV32B_ZBA) op = ALU_B_SH1ADD;
          {7'b001_0000, 3'b100}: if (RV32B_ZBA) op = ALU_B_SH2ADD;
          {7'b001_0000, 3'b110}: if (RV32B_ZBA) op = ALU_B_SH3ADD;
          {7'b000_0101, 3'b100}: if (RV32B_ZBB) op = ALU_B_MIN;
          {7'b000_0101, 3'b101}: if (RV32B_ZBB) op = ALU_B_MINU;
          {7'b000_0101, 3'b110}: if (RV32B_ZBB) op = ALU_B_MAX;
          {7'b000_0101, 3'b111}: if (RV32B_ZBB) op = ALU_B_MAXU;
          {7'b010_0000, 3'b111}: if (RV32B_ZBB) op = ALU_B_ANDN;
          {7'b010_0000, 3'b110}: if (RV32B_ZBB) op = ALU_B_ORN;
          {7'b010_0000, 3'b100}: if (RV32B_ZBB) op = ALU_B_XNOR;
          {7'b011_0000, 3'b001}: if (RV32B_ZBB) op = ALU_B_ROL;
          {7'b011_0000, 3'b101}: if (RV32B_ZBB) op = ALU_B_ROR;
          {7'b000_0100, 3'b100}: begin // zext.h, rs2 field must be x0
            b_sel = OP_B_NONE;
            if (zcb_ok && (instr_i.r.rs2 == 5'd0)) op = ALU_B_ZEXT_H;
          end
          {7'b000_0101, 3'b001}: if (RV32B_ZBC) op = ALU_B_CLMUL;
          {7'b000_0101, 3'b011}: if (RV32B_ZBC) op = ALU_B_CLMULH;
          {7'b000_0101, 3'b010}: if (RV32B_ZBC) op = ALU_B_CLMULR;
          {7'b001_0100, 3'b001}: if (RV32B_ZBS) op = ALU_B_BSET;
          {7'b010_0100, 3'b001}: if (RV32B_ZBS) op = ALU_B_BCLR;
          {7'b011_0100, 3'b001}: if (RV32B_ZBS) op = ALU_B_BINV;
          {7'b010_0100, 3'b101}: if (RV32B_ZBS) op = ALU_B_BEXT;
          default: op = ALU_B_NOP; // Unknown funct7/funct3
        endcase
      end

      OPCODE_OPIMM: begin
        b_sel = OP_B_NONE; // Unary by default, index forms override
        // I view, imm12 holds funct7 above the shamt or the unary selector
        unique casez ({instr_i.i.imm12, instr_i.i.funct3})
          {12'b0110000_00000, 3'b001}: if (RV32B_ZBB) op = ALU_B_CLZ;
          {12'b0110000_00001, 3'b001}: if (RV32B_ZBB) op = ALU_B_CTZ;
          {12'b0110000_00010, 3'b001}: if (RV32B_ZBB) op = ALU_B_CPOP;
          {12'b0010100_00111, 3'b101}: if (RV32B_ZBB) op = ALU_B_ORC_B;
          {12'b0110100_11000, 3'b101}: if (RV32B_ZBB) op = ALU_B_REV8;
          {12'b0110000_00100, 3'b001}: if (zcb_ok)    op = ALU_B_SEXT_B;
          {12'b0110000_00101, 3'b001}: if (zcb_ok)    op = ALU_B_SEXT_H;
          {12'b0110000_?????, 3'b101}: begin // rori
            b_sel = OP_B_IMM;
            if (RV32B_ZBB) op = ALU_B_ROR;
          end
          {12'b0010100_?????, 3'b001}: begin // bseti
            b_sel = OP_B_IMM;
            if (RV32B_ZBS) op = ALU_B_BSET;
          end
          {12'b0100100_?????, 3'b001}: begin // bclri
            b_sel = OP_B_IMM;
            if (RV32B_ZBS) op = ALU_B_BCLR;
          end
          {12'b0110100_?????, 3'b001}: begin // binvi
            b_sel = OP_B_IMM;
            if (RV32B_ZBS) op = ALU_B_BINV;
          end
          {12'b0100100_?????, 3'b101}: begin // bexti
            b_sel = OP_B_IMM;
            if (RV32B_ZBS) op = ALU_B_BEXT;
          end
          default: op = ALU_B_NOP;
        endcase
      end

      default: op = ALU_B_NOP; // Not an opcode of this slice
    endcase

    // Only a claimed operator makes the instruction legal
    decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
    if (op != ALU_B_NOP) begin
      decoder_ctrl_o.illegal_insn     = 1'b0;
      decoder_ctrl_o.alu_en           = 1'b1;
      decoder_ctrl_o.alu_operator     = op;
      decoder_ctrl_o.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
      decoder_ctrl_o.alu_op_b_mux_sel = b_sel;
      decoder_ctrl_o.rf_re            = {b_sel == OP_B_REGB_OR_FWD, 1'b1};
      decoder_ctrl_o.rf_we            = 1'b1;
    end
  end

  // Illegal must never reach the ALU or the register file
  always_comb begin
    illegal_quiet_a : assert final (!decoder_ctrl_o.illegal_insn ||
                                    (!decoder_ctrl_o.alu_en && !decoder_ctrl_o.rf_we))
      else $error("illegal instruction with alu_en or rf_we set");
  end

endmodule

// ==== rtl/bmu_ex_if.sv ====
////////////////////////////////////////
// Decode to execute bundle
// Fields other than valid mean nothing while valid is low
////////////////////////////////////////
`timescale 1ns/1ns

interface bmu_ex_if;

  import bmu_isa_pkg::*;

  logic        valid;
  alu_op_e     alu_operator;
  logic [31:0] operand_a;    // rs1 after forwarding
  logic [31:0] operand_b;    // rs2, immediate index or zero
  logic [4:0]  rd;
  logic        rf_we;
  logic        illegal;

  modport id (output valid, alu_operator, operand_a, operand_b, rd, rf_we, illegal);
  modport ex (input  valid, alu_operator, operand_a, operand_b, rd, rf_we, illegal);

endinterface

// ==== rtl/bmu_isa_pkg.sv ====
////////////////////////////////////////
// RV32 B-extension encodings shared by decode and execute
// Only OP and OP-IMM are described, no compressed formats
// Operator encodings are internal and may be renumbered
////////////////////////////////////////
package bmu_isa_pkg;

  // Major opcodes handled by the slice
  localparam logic [6:0] OPCODE_OP    = 7'h33;
  localparam logic [6:0] OPCODE_OPIMM = 7'h13;

  // Configured B subsets
  typedef enum logic [1:0] {
    B_NONE          = 2'b00,
    ZBA_ZBB_ZBS     = 2'b01,
    ZBA_ZBB_ZBC_ZBS = 2'b10
  } b_ext_e;

  // ALU operator, NOP marks "nothing decoded"
  typedef enum logic [4:0] {
    ALU_B_NOP,
    ALU_B_SH1ADD, ALU_B_SH2ADD, ALU_B_SH3ADD,     // Zba
    ALU_B_MIN, ALU_B_MINU, ALU_B_MAX, ALU_B_MAXU, // Zbb compare
    ALU_B_ANDN, ALU_B_ORN, ALU_B_XNOR,           // Zbb logic
    ALU_B_ROL, ALU_B_ROR,
    ALU_B_ZEXT_H,
    ALU_B_CLMUL, ALU_B_CLMULH, ALU_B_CLMULR,     // Zbc
    ALU_B_BSET, ALU_B_BCLR, ALU_B_BINV, ALU_B_BEXT, // Zbs
    ALU_B_CLZ, ALU_B_CTZ, ALU_B_CPOP,            // Zbb unary
    ALU_B_ORC_B, ALU_B_REV8,
    ALU_B_SEXT_B, ALU_B_SEXT_H
  } alu_op_e;

  // Operand B source
  typedef enum logic [1:0] {
    OP_B_REGB_OR_FWD = 2'b00,
    OP_B_IMM         = 2'b01, // Shift amount or bit index
    OP_B_NONE        = 2'b10
  } op_b_sel_e;

  // Operand A source
  typedef enum logic {
    OP_A_REGA_OR_FWD = 1'b0,
    OP_A_NONE        = 1'b1
  } op_a_sel_e;

  ////////////////////////////////////////
  // Instruction word views
  ////////////////////////////////////////
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm12; // funct7 on top of shamt for shift-like forms
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

endpackage

// ==== rtl/bmu_regfile.sv ====
////////////////////////////////////////
// 31 x 32 register file, x0 reads as zero
// No write-to-read bypass, the core forwards
////////////////////////////////////////
`timescale 1ns/1ns

module bmu_regfile (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [4:0]  raddr_a_i,
  input  logic [4:0]  raddr_b_i,
  output logic [31:0] rdata_a_o,
  output logic [31:0] rdata_b_o,
  input  logic        we_i,
  input  logic [4:0]  waddr_i,
  input  logic [31:0] wdata_i
);

  logic [31:0] regs [1:31]; // x1..x31, no storage for x0

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != 5'd0)) begin // Writes to x0 dropped
      regs[waddr_i] <= wdata_i;
    end
  end

  // Asynchronous read ports
  assign rdata_a_o = (raddr_a_i == 5'd0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == 5'd0) ? '0 : regs[raddr_b_i];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the bmu_core testbench with Verilator, run from the project root

if ! verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_bmu_core -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_bmu_core > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" sim.log; then
  echo "Simulation reported errors"
  exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

// ==== testbench/tb_bmu_ref.svh ====
////////////////////////////////////////
// Reference decode and execute for the B slice testbench
// Included inside the testbench module body
// Assumes Zba+Zbb+Zbc+Zbs, Zcb rule follows REF_ZBB and REF_ZC
////////////////////////////////////////
`ifndef TB_BMU_REF_SVH
`define TB_BMU_REF_SVH

  localparam bit REF_ZBB = 1'b1; // Zbb configured in the DUT
  localparam bit REF_ZC  = 1'b1; // Zcb expansions allowed

  logic [31:0] model_regs [32]; // Architectural state in program order, x0 stays zero

  // Zero run length from the top or the bottom of a word
  function automatic logic [31:0] count_zeros(input logic [31:0] v, input bit from_msb);
    logic [31:0] n;
    n = 0;
    for (int i = 0; i < 32; i++) begin
      if (v[from_msb ? 31 - i : i]) break;
      n++;
    end
    return n;
  endfunction

  // Carry-less multiply per the Zbc spec loops, 0 low, 1 high, 2 reversed
  function automatic logic [31:0] clmul_ref(input logic [31:0] a, input logic [31:0] b,
                                            input int mode);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < 32; i++) begin
      if (b[i]) begin
        if (mode == 0) r = r ^ (a << i);
        else if (mode == 1 && i > 0) r = r ^ (a >> (32 - i));
        else if (mode == 2) r = r ^ (a >> (31 - i));
      end
    end
    return r;
  endfunction

  // Decode one word bitwise and compute its result from rs1 and rs2 values
  function automatic logic [31:0] ref_exec(input logic [31:0] w, input logic cmp,
                                           input logic [31:0] a, input logic [31:0] rb,
                                           output logic legal);
    logic [31:0] r;
    logic [4:0]  si; // Immediate shamt or index
    logic [4:0]  sr; // Register shamt or index
    logic        zcb;
    r     = '0;
    legal = 1'b1;
    si    = w[24:20];
    sr    = rb[4:0];
    zcb   = REF_ZBB || (REF_ZC && cmp);
    if (w[6:0] == 7'b0110011) begin
      case ({w[31:25], w[14:12]})
        10'b0010000_010: r = (a << 1) + rb;
        10'b0010000_100: r = (a << 2) + rb;
        10'b0010000_110: r = (a << 3) + rb;
        10'b0000101_100: r = ($signed(a) <= $signed(rb)) ? a : rb; // min
        10'b0000101_101: r = (a <= rb) ? a : rb;
        10'b0000101_110: r = ($signed(a) >= $signed(rb)) ? a : rb; // max
        10'b0000101_111: r = (a >= rb) ? a : rb;
        10'b0100000_111: r = a & ~rb;
        10'b0100000_110: r = a | ~rb;
        10'b0100000_100: r = a ~^ rb;
        10'b0110000_001: r = (a << sr) | (a >> (6'd32 - {1'b0, sr})); // rol
        10'b0110000_101: r = (a >> sr) | (a << (6'd32 - {1'b0, sr})); // ror
        10'b0000101_001: r = clmul_ref(a, rb, 0);
        10'b0000101_011: r = clmul_ref(a, rb, 1);
        10'b0000101_010: r = clmul_ref(a, rb, 2);
        10'b0010100_001: r = a | (32'd1 << sr);
        10'b0100100_001: r = a & ~(32'd1 << sr);
        10'b0110100_001: r = a ^ (32'd1 << sr);
        10'b0100100_101: r = (a >> sr) & 32'd1;
        10'b0000100_100: begin // zext.h needs rs2 field zero
          if (zcb && si == 5'd0) r = {16'h0000, a[15:0]};
          else legal = 1'b0;
        end
        default: legal = 1'b0;
      endcase
    end else if (w[6:0] == 7'b0010011) begin
      casez ({w[31:20], w[14:12]})
        {12'h600, 3'b001}: r = count_zeros(a, 1'b1);
        {12'h601, 3'b001}: r = count_zeros(a, 1'b0);
        {12'h602, 3'b001}: r = $countones(a);
        {12'h604, 3'b001}: if (zcb) r = 32'($signed(a[7:0])); else legal = 1'b0;
        {12'h605, 3'b001}: if (zcb) r = 32'($signed(a[15:0])); else legal = 1'b0;
        {12'h287, 3'b101}: begin
          for (int j = 0; j < 4; j++) r[8*j +: 8] = (a[8*j +: 8] != 0) ? 8'hff : 8'h00;
        end
        {12'h698, 3'b101}: r = {<<8{a}};
        {12'b0110000_?????, 3'b101}: r = (a >> si) | (a << (6'd32 - {1'b0, si}));
        {12'b0010100_?????, 3'b001}: r = a | (32'd1 << si);
        {12'b0100100_?????, 3'b001}: r = a & ~(32'd1 << si);
        {12'b0110100_?????, 3'b001}: r = a ^ (32'd1 << si);
        {12'b0100100_?????, 3'b101}: r = (a >> si) & 32'd1;
        default: legal = 1'b0;
      endcase
    end else begin
      legal = 1'b0; // Foreign opcode
    end
    if (!legal) r = '0;
    return r;
  endfunction

`endif

// ==== testbench/tb_bmu_core.sv ====
////////////////////////////////////////
// Drives bmu_core in the full B configuration with Zcb
// Reference model runs in program order at issue time
// Preload happens only while the pipeline is empty
////////////////////////////////////////
`timescale 1ns/1ns

module tb_bmu_core;

  `include "tb_bmu_ref.svh"

  // Test lengths also set the timeout
  localparam int N_INSTR     = 57 + 52 + 20 + 40 + 12;
  localparam int N_PRELOAD   = 31;
  localparam int N_IDLE      = 3 + 2 + 3 + 4;
  localparam int TIMEOUT_CYC = N_INSTR + N_PRELOAD + N_IDLE + 20;

  // {funct7, funct3} of the R-type ops except zext.h
  localparam logic [9:0] R_OPS [19] = '{
    10'b0010000_010, 10'b0010000_100, 10'b0010000_110, 10'b0000101_100,
    10'b0000101_101, 10'b0000101_110, 10'b0000101_111, 10'b0100000_111,
    10'b0100000_110, 10'b0100000_100, 10'b0110000_001, 10'b0110000_101,
    10'b0000101_001, 10'b0000101_011, 10'b0000101_010, 10'b0010100_001,
    10'b0100100_001, 10'b0110100_001, 10'b0100100_101};
  localparam logic [9:0] IMM_OPS [5] = '{ // rori bseti bclri binvi bexti
    10'b0110000_101, 10'b0010100_001, 10'b0100100_001, 10'b0110100_001, 10'b0100100_101};
  localparam logic [14:0] UN_OPS [7] = '{ // clz ctz cpop sext.b sext.h orc.b rev8
    {12'h600, 3'b001}, {12'h601, 3'b001}, {12'h602, 3'b001}, {12'h604, 3'b001},
    {12'h605, 3'b001}, {12'h287, 3'b101}, {12'h698, 3'b101}};

  typedef struct packed {
    int          cyc;  // Cycle count expected at the retire sample
    logic        ill;
    logic [4:0]  rd;
    logic [31:0] res;
  } exp_t;

  logic        clk_i, rst_n_i;
  logic        instr_valid_i, instr_compressed_i;
  logic [31:0] instr_i;
  logic        pl_we_i;
  logic [4:0]  pl_addr_i;
  logic [31:0] pl_data_i;
  logic        retire_valid_o, retire_illegal_o;
  logic [4:0]  retire_rd_o;
  logic [31:0] retire_result_o;

  exp_t        exp_q [$]; // Scoreboard in program order
  exp_t        got_e;
  int          cyc, errors, n_retired;
  logic [31:0] seed;
  logic [4:0]  prev_rd, rd;

  bmu_core #(.B_EXT(bmu_isa_pkg::ZBA_ZBB_ZBC_ZBS), .ZC_EXT(1'b1)) u_bmu_core (.*);

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [4:0] rand_reg();
    return 5'(lcg_next() >> 27); // Upper bits are the better ones
  endfunction

  function automatic logic [31:0] enc_r(input logic [9:0] op, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [4:0] rd_f);
    return {op[9:3], rs2, rs1, op[2:0], rd_f, 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                        input logic [4:0] rs1, input logic [4:0] rd_f);
    return {imm, rs1, f3, rd_f, 7'h13};
  endfunction

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk_i);
    #5;
  endtask

  // Predict, update the model, then drive for one cycle
  task automatic issue(input logic [31:0] w, input logic c);
    logic        legal;
    logic [31:0] res;
    exp_t        e;
    res = ref_exec(w, c, model_regs[w[19:15]], model_regs[w[24:20]], legal);
    if (legal && w[11:7] != 5'd0) model_regs[w[11:7]] = res;
    e = '{cyc: cyc + 2, ill: !legal, rd: w[11:7], res: res};
    exp_q.push_back(e);
    instr_valid_i      = 1'b1;
    instr_i            = w;
    instr_compressed_i = c;
    @(posedge clk_i);
    #5;
    instr_valid_i = 1'b0;
  endtask

  // Cycle count and watchdog
  always @(posedge clk_i) begin
    cyc++;
    if (cyc > TIMEOUT_CYC) begin
      $display("Timeout after %0d cycles with %0d errors", cyc, errors);
      $display("Done: errors found");
      $finish;
    end
  end

  // Compare retires against the scoreboard at mid-cycle
  always @(negedge clk_i) begin
    if (rst_n_i && retire_valid_o === 1'b1) begin
      n_retired++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("Retire at %0t with no instruction outstanding", $time);
      end else begin
        got_e = exp_q.pop_front();
        check_eq("retire cycle", cyc, got_e.cyc);
        check_eq("illegal flag", retire_illegal_o, got_e.ill);
        check_eq("rd", retire_rd_o, got_e.rd);
        check_eq("result", retire_result_o, got_e.res);
      end
    end
  end

  initial begin
    clk_i              = 1'b0;
    rst_n_i            = 1'b0;
    instr_valid_i      = 1'b0;
    instr_i            = '0;
    instr_compressed_i = 1'b0;
    pl_we_i            = 1'b0;
    pl_addr_i          = '0;
    pl_data_i          = '0;
    seed               = 32'h6f3c;
    cyc                = 0;
    errors             = 0;
    n_retired          = 0;
    for (int r = 0; r < 32; r++) model_regs[r] = '0;
    repeat (3) @(posedge clk_i);
    #5 rst_n_i = 1'b1;
    idle(2); // No retire may show up here

    ////////////////////////////////////////
    // Preload all registers
    ////////////////////////////////////////
    for (int r = 1; r < 32; r++) begin
      pl_we_i = 1'b1;
      pl_addr_i = 5'(r);
      pl_data_i = lcg_next();
      model_regs[r] = pl_data_i;
      idle(1);
    end
    pl_we_i = 1'b0;

    // R-type ops on random pairs with an idle gap now and then
    for (int k = 0; k < 19; k++) begin
      for (int n = 0; n < 3; n++) begin
        issue(enc_r(R_OPS[k], rand_reg(), rand_reg(), rand_reg()), 1'b0);
      end
      if (k % 5 == 4) idle(1);
    end
    // Immediate and unary forms
    for (int n = 0; n < 4; n++) begin
      for (int k = 0; k < 5; k++) begin
        issue(enc_i({IMM_OPS[k][9:3], rand_reg()}, IMM_OPS[k][2:0], rand_reg(), rand_reg()),
              1'b0);
      end
      for (int k = 0; k < 7; k++) begin
        issue(enc_i(UN_OPS[k][14:3], UN_OPS[k][2:0], rand_reg(), rand_reg()), 1'b0);
      end
      issue(enc_r(10'b0000100_100, 5'd0, rand_reg(), rand_reg()), 1'b0); // zext.h
    end
    // Dependent chain through forwarding with x0 as every fifth destination
    prev_rd = rand_reg();
    for (int n = 0; n < 20; n++) begin
      rd = (n % 5 == 4) ? 5'd0 : rand_reg();
      issue(enc_r(R_OPS[lcg_next() % 19], prev_rd, prev_rd, rd), 1'b0);
      prev_rd = rd;
    end
    // Illegal encodings each followed by max rd,rd,rd to read rd back
    for (int n = 0; n < 20; n++) begin
      rd = rand_reg() | 5'd1;
      case (n % 3)
        0: issue({20'(lcg_next() >> 12), rd, 7'h0b}, 1'b0); // Foreign opcode
        // Unknown funct7
        1: issue(enc_r({7'h7f, 3'(lcg_next())}, rand_reg(), rand_reg(), rd), 1'b0);
        default: issue(enc_r(10'b0000100_100, rand_reg() | 5'd1, rand_reg(), rd), 1'b0);
      endcase
      issue(enc_r(10'b0000101_110, rd, rd, rd), 1'b0);
    end
    // Zcb rule with and without the compressed flag
    for (int c = 0; c < 2; c++) begin
      for (int n = 0; n < 2; n++) begin
        issue(enc_i(12'h604, 3'b001, rand_reg(), rand_reg()), c[0]);
        issue(enc_i(12'h605, 3'b001, rand_reg(), rand_reg()), c[0]);
        issue(enc_r(10'b0000100_100, 5'd0, rand_reg(), rand_reg()), c[0]);
      end
    end
    idle(4); // Drain the pipeline

    if (exp_q.size() != 0) begin
      errors++;
      $display("Scoreboard still holds %0d instructions at end of test", exp_q.size());
    end
    $display("Checks finished: %0d errors, %0d retires seen", errors, n_retired);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+testbench
rtl/bmu_isa_pkg.sv
rtl/bmu_ctrl_pkg.sv
rtl/bmu_ex_if.sv
rtl/bmu_decoder.sv
rtl/bmu_regfile.sv
rtl/bmu_alu.sv
rtl/bmu_core.sv
testbench/tb_bmu_core.sv
